/* Bender.yml */
package:
  name: cg_clkgate

sources:
  - common/cg_cfg_pkg.sv
  - common/cg_src_pkg.sv
  - cfg/cg_cfg_regs.sv
  - wake/cg_wake_extend.sv
  - wake/cg_wake_sources.sv
  - verilog/cg_clk_ctrl.sv
  - verilog/cg_top.sv
  - target: test
    files:
      - verification/tb_clk_gen.sv
      - verification/tb_cg_top.sv

/* all.f */
common/cg_cfg_pkg.sv
common/cg_src_pkg.sv
cfg/cg_cfg_regs.sv
wake/cg_wake_extend.sv
wake/cg_wake_sources.sv
verilog/cg_clk_ctrl.sv
verilog/cg_top.sv
verification/tb_clk_gen.sv
verification/tb_cg_top.sv

/* cfg/cg_cfg_regs.sv */
`timescale 1ns/100ps

module cg_cfg_regs
    import cg_cfg_pkg::*;
(
    input  logic               iosf_cdc_clock,
    input  logic               i_rst_n,
    input  logic               i_cfg_we,            // Write strobe, one cycle
    input  logic [CFG_W-1:0]   i_cfg_wdata,
    output logic [CFG_W-1:0]   o_cfg_rdata,         // Raw readback
    output logic [TIMER_W-1:0] o_t_clkgate,
    output logic [TIMER_W-1:0] o_t_clkwake,
    output logic               o_clkgate_disabled
);

    cfg_word_u cfg_q;

    // Single config word, reserved bits masked off on write
    always_ff @(posedge iosf_cdc_clock) begin
        if (!i_rst_n) begin
            cfg_q.raw <= CFG_RESET_WORD;
        end else if (i_cfg_we) begin
            cfg_q.raw <= i_cfg_wdata & CFG_WMASK;
        end
    end

    assign o_cfg_rdata        = cfg_q.raw;           // Bus view
    assign o_t_clkgate        = cfg_q.f.t_clkgate;   // Field view to controller
    assign o_t_clkwake        = cfg_q.f.t_clkwake;
    assign o_clkgate_disabled = cfg_q.f.clkgate_disabled;

    // Reserved field stays clear through reset and every write
    a_rsvd_zero: assert property (
        @(posedge iosf_cdc_clock) disable iff (!i_rst_n)
        cfg_q.f.rsvd == '0
    ) else $error("Reserved config bits set");

endmodule

/* common/cg_cfg_pkg.sv */
package cg_cfg_pkg;

    // Configuration word layout
    localparam int CFG_W   = 16;
    localparam int TIMER_W = 4;                          // Gate and wake hysteresis timers
    localparam int RSVD_W  = CFG_W - (2 * TIMER_W) - 1;  // Upper reserved bits

    // Field view of the configuration word, LSB first from the bottom
    typedef struct packed {
        logic [RSVD_W-1:0]  rsvd;                // [15:9] reads zero
        logic               clkgate_disabled;    // [8]
        logic [TIMER_W-1:0] t_clkwake;           // [7:4]
        logic [TIMER_W-1:0] t_clkgate;           // [3:0]
    } cfg_fields_t;

    // Bus side uses raw, controller side uses f
    typedef union packed {
        logic [CFG_W-1:0] raw;
        cfg_fields_t      f;
    } cfg_word_u;

    localparam logic [CFG_W-1:0] CFG_RESET_WORD = 16'h0024;  // Gate 4, wake 2, gating on
    localparam logic [CFG_W-1:0] CFG_WMASK      = 16'h01FF;  // Writable bits

    // Clock controller state encoding
    localparam int              ST_W    = 2;
    localparam logic [ST_W-1:0] ST_OFF  = 2'd0;  // Clock off, request idle or dropping
    localparam logic [ST_W-1:0] ST_REQ  = 2'd1;  // Request out, waiting on ack
    localparam logic [ST_W-1:0] ST_WAKE = 2'd2;  // Wake hysteresis
    localparam logic [ST_W-1:0] ST_ON   = 2'd3;  // Clock on, gate hysteresis

endpackage

/* common/cg_src_pkg.sv */
package cg_src_pkg;

    // CDC counts on each side
    localparam int N_IOSF_CDC      = 5;
    localparam int N_NON_IOSF_CDC  = 4;

    // Gated-clock request/ack counts
    localparam int N_IOSF_GCLK     = 5;
    localparam int N_NON_IOSF_GCLK = 5;

    // Derived source widths
    localparam int N_CDC  = N_IOSF_CDC + N_NON_IOSF_CDC;    // All clkreq / clkack bits
    localparam int N_GCLK = N_IOSF_GCLK + N_NON_IOSF_GCLK;  // All gclock req / ack bits

    // One fabric ISM state
    localparam int ISM_W = 3;

    // Synchronizer depth for every async level
    localparam int SYNC_STAGES = 2;

    // Minimum hold once a source drops
    localparam int EXT_CYCLES = 4;
    localparam int EXT_W      = $clog2(EXT_CYCLES + 1);  // Hold counter width

endpackage

/* verification/tb_cg_top.sv */
`timescale 1ns/100ps

module tb_cg_top
    import cg_cfg_pkg::*, cg_src_pkg::*;
();

    // Per-test cycle budgets plus a margin set the watchdog
    localparam int T_BUDGET = 30 + 60 + 120 + 160 + 320 + 220 + 200;

    logic                        clk, rst_n;
    logic [N_IOSF_CDC*ISM_W-1:0] ism;
    logic [N_IOSF_CDC-1:0]       iosf_clkreq, iosf_clkack;
    logic [N_NON_IOSF_CDC-1:0]   non_iosf_clkreq, non_iosf_clkack;
    logic [N_IOSF_GCLK-1:0]      iosf_greq, iosf_gack;
    logic [N_NON_IOSF_GCLK-1:0]  non_iosf_greq, non_iosf_gack;
    logic                        pwrgate_dis, pmc_wake, pgcb_pok, pgcb_idle;
    logic                        clkack, cfg_we;
    logic [CFG_W-1:0]            cfg_wdata, cfg_rdata;
    logic                        clkreq, clk_en;

    int          errors = 0;
    int          tests  = 0;
    logic [31:0] lfsr   = 32'hccfd_6d61;
    logic [3:0]  exp_tg, exp_tw;     // Expected timers from written config
    logic        exp_dis;
    logic        pg_last;            // Previous pwrgate level, for change detect
    logic        src_ess, src_acc, wake_in;
    int          quiet_cnt;          // Cycles with no effective wake source
    int          ack_cnt;            // Cycles with ack high and clock off

    tb_clk_gen u_clk (.o_clk(clk), .o_rst_n(rst_n));

    cg_top UUT (
        .iosf_cdc_clock(clk), .i_rst_n(rst_n),
        .i_iosf_ism_fabric(ism),
        .i_iosf_clkreq(iosf_clkreq), .i_non_iosf_clkreq(non_iosf_clkreq),
        .i_iosf_clkack(iosf_clkack), .i_non_iosf_clkack(non_iosf_clkack),
        .i_iosf_gclock_req(iosf_greq), .i_non_iosf_gclock_req(non_iosf_greq),
        .i_iosf_gclock_ack(iosf_gack), .i_non_iosf_gclock_ack(non_iosf_gack),
        .i_pwrgate_disabled(pwrgate_dis), .i_pmc_wake(pmc_wake),
        .i_pgcb_pok(pgcb_pok), .i_pgcb_idle(pgcb_idle), .i_clkack(clkack),
        .i_cfg_we(cfg_we), .i_cfg_wdata(cfg_wdata), .o_cfg_rdata(cfg_rdata),
        .o_clkreq(clkreq), .o_clk_en(clk_en)
    );

    // Galois LFSR stepped once per bit taken
    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v = (v << 1) | lfsr[0];
        end
        return v;
    endfunction

    // SoC model returns clkreq as ack after 1 to 4 cycles
    initial begin : soc_model
        int   n;
        logic target;
        clkack = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (clkreq !== clkack) begin
                target = clkreq;
                n = rand_bits(2);
                repeat (n + 1) @(posedge clk);
                #1 clkack = target;
            end
        end
    end

    // Reference wake view from the class rules
    assign src_ess = (|iosf_clkreq) | (|non_iosf_clkreq) | (|iosf_clkack) | (|non_iosf_clkack)
                     | pmc_wake | !pgcb_idle;
    assign src_acc = (|ism) | (|iosf_greq) | (|non_iosf_greq) | (|iosf_gack) | (|non_iosf_gack)
                     | (pwrgate_dis != pg_last);
    assign wake_in = src_ess || (pgcb_pok && (src_acc || exp_dis));

    always @(posedge clk) begin
        pg_last <= pwrgate_dis;
        if (!rst_n || wake_in) quiet_cnt <= 0;
        else if (quiet_cnt < 1000) quiet_cnt <= quiet_cnt + 1;
        if (!rst_n || !clkack || clk_en) ack_cnt <= 0;   // Counts the sampling edge too
        else ack_cnt <= ack_cnt + 1;
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("Mismatch %s: got %h expected %h", name, got, exp);
        errors++;
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp) else report_mismatch(name, got, exp);
    endtask

    a_wake_time: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(clk_en) |-> (ack_cnt == SYNC_STAGES + exp_tw + 1))
        else report_mismatch("o_clk_en wake delay", $sampled(ack_cnt) - 1,
                             SYNC_STAGES + exp_tw);

    a_gate_hold: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(clk_en) |-> (quiet_cnt >= SYNC_STAGES + EXT_CYCLES + exp_tg + 1))
        else report_mismatch("o_clk_en gate delay", $sampled(quiet_cnt),
                             SYNC_STAGES + EXT_CYCLES + exp_tg + 1);

    a_req_rise: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(clkreq) |-> !clk_en)
        else begin
            $display("clkreq rose while the clock was already enabled");
            errors++;
        end

    a_req_fall: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(clkreq) |-> !clk_en)
        else begin
            $display("clkreq fell before the clock enable fell");
            errors++;
        end

    a_ack_fall: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(clkack) |-> !clkreq)
        else begin
            $display("clkack fell while clkreq was still high");
            errors++;
        end

    function automatic logic sig_val(input int which);
        case (which)
            0:       return clkreq;
            1:       return clk_en;
            default: return clkack;
        endcase
    endfunction

    // Waits for a DUT output level, bounded
    task automatic wait_for(input int which, input logic val, input int max_cyc,
                            input string what);
        int n;
        n = 0;
        while (sig_val(which) !== val && n < max_cyc) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (sig_val(which) !== val) begin
            $display("Timed out waiting for %s", what);
            errors++;
        end
    endtask

    task automatic cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // Write then read back on the next cycle
    task automatic write_cfg(input logic [CFG_W-1:0] data);
        logic [CFG_W-1:0] exp;
        exp       = data & 16'h01FF;
        cfg_we    = 1'b1;
        cfg_wdata = data;
        cycles(1);
        cfg_we    = 1'b0;
        exp_tg    = exp[3:0];
        exp_tw    = exp[7:4];
        exp_dis   = exp[8];
        check_val("o_cfg_rdata", cfg_rdata, exp);
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests++;
        $display("Test %-12s %s", name, (errors == errs_before) ? "ok" : "FAILED");
    endtask

    initial begin : watchdog
        #(T_BUDGET * 10);
        $display("Watchdog expired before the tests finished");
        $display("Simulation failed");
        $finish;
    end

    initial begin : stimulus
        int e;
        ism             = '0;
        iosf_clkreq     = '0;
        non_iosf_clkreq = '0;
        iosf_clkack     = '0;
        non_iosf_clkack = '0;
        iosf_greq       = '0;
        non_iosf_greq   = '0;
        iosf_gack       = '0;
        non_iosf_gack   = '0;
        pwrgate_dis     = 1'b0;
        pmc_wake        = 1'b0;
        pgcb_pok        = 1'b1;             // Idle PGCB, power ok
        pgcb_idle       = 1'b1;
        cfg_we          = 1'b0;
        cfg_wdata       = '0;
        exp_tg          = 4'd4;
        exp_tw          = 4'd2;
        exp_dis         = 1'b0;
        @(posedge rst_n);
        cycles(1);

        e = errors;
        check_val("o_clkreq", clkreq, 0);
        check_val("o_clk_en", clk_en, 0);
        check_val("o_cfg_rdata", cfg_rdata, 16'h0024);
        cycles(12);
        check_val("o_clkreq", clkreq, 0);   // Nothing pending
        end_test("reset", e);

        e = errors;
        write_cfg(16'hFFFF);
        write_cfg(16'h0053);                // Gate 3, wake 5
        // One cycle of clkgate_disabled with pok up requests the clock
        wait_for(1, 1'b1, 40, "o_clk_en to rise after the disable write");
        wait_for(1, 1'b0, 40, "o_clk_en to fall after the disable write");
        wait_for(0, 1'b0, 5, "o_clkreq to fall");
        wait_for(2, 1'b0, 10, "i_clkack to fall");
        end_test("config", e);

        e = errors;
        iosf_clkreq[2] = 1'b1;
        wait_for(0, 1'b1, 20, "o_clkreq to rise");
        wait_for(1, 1'b1, 60, "o_clk_en to rise");
        cycles(10);
        end_test("wake", e);

        e = errors;
        iosf_clkreq[2] = 1'b0;
        cycles(6);
        iosf_gack[1] = 1'b1;                // Restarts the gate count
        cycles(1);
        iosf_gack[1] = 1'b0;
        wait_for(1, 1'b0, 60, "o_clk_en to fall");
        wait_for(0, 1'b0, 5, "o_clkreq to fall");
        wait_for(2, 1'b0, 10, "i_clkack to fall");
        end_test("gating", e);

        e = errors;
        write_cfg(16'h0122);                // Disabled with pok wakes the clock
        pmc_wake = 1'b1;
        wait_for(1, 1'b1, 60, "o_clk_en to rise");
        pmc_wake = 1'b0;
        cycles(40);
        check_val("o_clk_en", clk_en, 1);
        pgcb_idle = 1'b0;                   // Essential source holds the clock
        ism[5:3]  = 3'b010;
        pgcb_pok  = 1'b0;
        cycles(30);
        check_val("o_clk_en", clk_en, 1);
        pgcb_idle = 1'b1;
        wait_for(1, 1'b0, 60, "o_clk_en to fall with pok low");
        wait_for(0, 1'b0, 10, "o_clkreq to fall");
        ism = '0;
        cycles(8);                          // ISM hold window drains
        write_cfg(16'h0023);
        pgcb_pok = 1'b1;
        cycles(12);
        check_val("o_clkreq", clkreq, 0);
        wait_for(2, 1'b0, 10, "i_clkack to fall");
        end_test("disable_pok", e);

        e = errors;
        pwrgate_dis = 1'b1;
        wait_for(0, 1'b1, 20, "o_clkreq to rise on pwrgate change");
        wait_for(1, 1'b1, 40, "o_clk_en to rise");
        wait_for(1, 1'b0, 60, "o_clk_en to fall");
        wait_for(0, 1'b0, 10, "o_clkreq to fall");
        end_test("pwrgate", e);

        cycles(5);
        $display("Tests run %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* verification/tb_clk_gen.sv */
`timescale 1ns/100ps

module tb_clk_gen (
    output logic o_clk,
    output logic o_rst_n
);

    // 10 ns free-running clock
    initial begin
        o_clk = 1'b0;
        forever #5 o_clk = ~o_clk;
    end

    // Reset low for 8 cycles, released just after an edge
    initial begin
        o_rst_n = 1'b0;
        repeat (8) @(posedge o_clk);
        #1 o_rst_n = 1'b1;
    end

endmodule

/* verilog/cg_clk_ctrl.sv */
`timescale 1ns/100ps

module cg_clk_ctrl
    import cg_cfg_pkg::*, cg_src_pkg::*;
(
    input  logic               iosf_cdc_clock,
    input  logic               i_rst_n,
    input  logic               i_wake_ess,          // Extended essential wakes
    input  logic               i_wake_acc,          // Extended accessible wakes
    input  logic               i_pgcb_pok,          // Async
    input  logic               i_clkack,            // Async, from SoC
    input  logic [TIMER_W-1:0] i_t_clkgate,
    input  logic [TIMER_W-1:0] i_t_clkwake,
    input  logic               i_clkgate_disabled,
    output logic               o_clkreq,
    output logic               o_clk_en
);

    logic [SYNC_STAGES-1:0] pok_sync_q, ack_sync_q;
    logic                   pok_s, ack_s;
    logic                   gate;               // Safe to gate this cycle
    logic [ST_W-1:0]        state_q;
    logic [TIMER_W-1:0]     timer_q;            // Shared wake / gate timer
    logic                   clkreq_q;
    logic [TIMER_W:0]       gate_run_q;         // Consecutive gate cycles, saturating

    always_ff @(posedge iosf_cdc_clock) begin
        if (!i_rst_n) begin
            pok_sync_q <= '0;
            ack_sync_q <= '0;
        end else begin
            pok_sync_q <= {pok_sync_q[SYNC_STAGES-2:0], i_pgcb_pok};
            ack_sync_q <= {ack_sync_q[SYNC_STAGES-2:0], i_clkack};
        end
    end

    assign pok_s = pok_sync_q[SYNC_STAGES-1];
    assign ack_s = ack_sync_q[SYNC_STAGES-1];

    // Accessible wakes and disable only matter with pok
    assign gate = !i_wake_ess && (!pok_s || (!i_wake_acc && !i_clkgate_disabled));

    always_ff @(posedge iosf_cdc_clock) begin
        if (!i_rst_n) begin
            state_q  <= ST_OFF;
            timer_q  <= '0;
            clkreq_q <= 1'b0;
        end else begin
            case (state_q)
                ST_OFF: begin
                    if (clkreq_q) begin
                        clkreq_q <= 1'b0;                // Enable fell last cycle
                    end else if (!gate && !ack_s) begin  // Old ack must be gone first
                        clkreq_q <= 1'b1;
                        state_q  <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    if (ack_s && (i_t_clkwake == '0)) begin
                        state_q <= ST_ON;                // No wake hysteresis
                        timer_q <= '0;
                    end else if (ack_s) begin
                        state_q <= ST_WAKE;
                        timer_q <= i_t_clkwake;
                    end
                end
                ST_WAKE: begin
                    if (timer_q <= TIMER_W'(1)) begin
                        state_q <= ST_ON;
                        timer_q <= '0;                   // Gate count starts clean
                    end else begin
                        timer_q <= timer_q - 1'b1;
                    end
                end
                default: begin                           // ST_ON
                    if (!gate) begin
                        timer_q <= '0;                   // Any wake restarts the count
                    end else if (timer_q >= i_t_clkgate) begin
                        state_q <= ST_OFF;               // t_clkgate+1 gate cycles seen
                    end else begin
                        timer_q <= timer_q + 1'b1;
                    end
                end
            endcase
        end
    end

    // Run length of the gate condition, any state
    always_ff @(posedge iosf_cdc_clock) begin
        if (!i_rst_n || !gate) begin
            gate_run_q <= '0;
        end else if (gate_run_q != '1) begin
            gate_run_q <= gate_run_q + 1'b1;
        end
    end

    assign o_clkreq = clkreq_q;
    assign o_clk_en = (state_q == ST_ON);

    a_en_needs_req: assert property (
        @(posedge iosf_cdc_clock) disable iff (!i_rst_n)
        $rose(o_clk_en) |-> o_clkreq
    ) else $error("Clock enable rose without clkreq");

    a_req_after_en: assert property (
        @(posedge iosf_cdc_clock) disable iff (!i_rst_n)
        $fell(o_clkreq) |-> !$past(o_clk_en)
    ) else $error("clkreq dropped while clock enabled");

    a_gate_full: assert property (
        @(posedge iosf_cdc_clock) disable iff (!i_rst_n)
        $fell(o_clk_en) |-> $past(gate && (gate_run_q >= {1'b0, i_t_clkgate}))
    ) else $error("Clock gated before full gate hysteresis");

endmodule

/* verilog/cg_top.sv */
`timescale 1ns/100ps

module cg_top
    import cg_cfg_pkg::*, cg_src_pkg::*;
(
    input  logic                        iosf_cdc_clock,
    input  logic                        i_rst_n,
    input  logic [N_IOSF_CDC*ISM_W-1:0] i_iosf_ism_fabric,
    input  logic [N_IOSF_CDC-1:0]       i_iosf_clkreq,
    input  logic [N_NON_IOSF_CDC-1:0]   i_non_iosf_clkreq,
    input  logic [N_IOSF_CDC-1:0]       i_iosf_clkack,
    input  logic [N_NON_IOSF_CDC-1:0]   i_non_iosf_clkack,
    input  logic [N_IOSF_GCLK-1:0]      i_iosf_gclock_req,
    input  logic [N_NON_IOSF_GCLK-1:0]  i_non_iosf_gclock_req,
    input  logic [N_IOSF_GCLK-1:0]      i_iosf_gclock_ack,
    input  logic [N_NON_IOSF_GCLK-1:0]  i_non_iosf_gclock_ack,
    input  logic                        i_pwrgate_disabled,
    input  logic                        i_pmc_wake,
    input  logic                        i_pgcb_pok,
    input  logic                        i_pgcb_idle,
    input  logic                        i_clkack,          // SoC ack
    input  logic                        i_cfg_we,
    input  logic [CFG_W-1:0]            i_cfg_wdata,
    output logic [CFG_W-1:0]            o_cfg_rdata,
    output logic                        o_clkreq,          // To SoC
    output logic                        o_clk_en           // Enable for the clock gate
);

    logic               wake_ess, wake_acc;
    logic [TIMER_W-1:0] t_clkgate, t_clkwake;
    logic               clkgate_disabled;

    cg_cfg_regs u_cfg (
        .iosf_cdc_clock     (iosf_cdc_clock),
        .i_rst_n            (i_rst_n),
        .i_cfg_we           (i_cfg_we),
        .i_cfg_wdata        (i_cfg_wdata),
        .o_cfg_rdata        (o_cfg_rdata),
        .o_t_clkgate        (t_clkgate),
        .o_t_clkwake        (t_clkwake),
        .o_clkgate_disabled (clkgate_disabled)
    );

    cg_wake_sources u_wake (
        .iosf_cdc_clock        (iosf_cdc_clock),
        .i_rst_n               (i_rst_n),
        .i_iosf_ism_fabric     (i_iosf_ism_fabric),
        .i_iosf_clkreq         (i_iosf_clkreq),
        .i_non_iosf_clkreq     (i_non_iosf_clkreq),
        .i_iosf_clkack         (i_iosf_clkack),
        .i_non_iosf_clkack     (i_non_iosf_clkack),
        .i_iosf_gclock_req     (i_iosf_gclock_req),
        .i_non_iosf_gclock_req (i_non_iosf_gclock_req),
        .i_iosf_gclock_ack     (i_iosf_gclock_ack),
        .i_non_iosf_gclock_ack (i_non_iosf_gclock_ack),
        .i_pwrgate_disabled    (i_pwrgate_disabled),
        .i_pmc_wake            (i_pmc_wake),
        .i_pgcb_idle           (i_pgcb_idle),
        .o_wake_ess            (wake_ess),
        .o_wake_acc            (wake_acc)
    );

    cg_clk_ctrl u_ctrl (
        .iosf_cdc_clock     (iosf_cdc_clock),
        .i_rst_n            (i_rst_n),
        .i_wake_ess         (wake_ess),
        .i_wake_acc         (wake_acc),
        .i_pgcb_pok         (i_pgcb_pok),
        .i_clkack           (i_clkack),
        .i_t_clkgate        (t_clkgate),
        .i_t_clkwake        (t_clkwake),
        .i_clkgate_disabled (clkgate_disabled),
        .o_clkreq           (o_clkreq),
        .o_clk_en           (o_clk_en)
    );

endmodule

/* wake/cg_wake_extend.sv */
`timescale 1ns/100ps

module cg_wake_extend
    import cg_src_pkg::*;
#(
    parameter int N = 1                   // Number of source bits
) (
    input  logic         iosf_cdc_clock,
    input  logic         i_rst_n,
    input  logic [N-1:0] i_async,         // Raw async levels
    output logic         o_wake_any       // Any bit synced or still held
);

    logic [SYNC_STAGES-1:0] sync_q    [N];
    logic [EXT_W-1:0]       ext_cnt_q [N];
    logic [N-1:0]           held;

    for (genvar i = 0; i < N; i++) begin : g_bit
        always_ff @(posedge iosf_cdc_clock) begin
            if (!i_rst_n) begin
                sync_q[i]    <= '0;
                ext_cnt_q[i] <= '0;
            end else begin
                sync_q[i] <= {sync_q[i][SYNC_STAGES-2:0], i_async[i]};  // Double sync
                if (sync_q[i][SYNC_STAGES-1]) begin
                    ext_cnt_q[i] <= EXT_W'(EXT_CYCLES);   // Reload while source active
                end else if (ext_cnt_q[i] != '0) begin
                    ext_cnt_q[i] <= ext_cnt_q[i] - 1'b1;  // Drain after source drops
                end
            end
        end

        // Synced level or hold window
        assign held[i] = sync_q[i][SYNC_STAGES-1] | (ext_cnt_q[i] != '0);

        // Hold counter never runs past its reload value
        a_cnt_max: assert property (
            @(posedge iosf_cdc_clock) disable iff (!i_rst_n)
            ext_cnt_q[i] <= EXT_W'(EXT_CYCLES)
        ) else $error("Wake hold counter above EXT_CYCLES on bit %0d", i);
    end

    assign o_wake_any = |held;

endmodule

/* wake/cg_wake_sources.sv */
`timescale 1ns/100ps

module cg_wake_sources
    import cg_src_pkg::*;
(
    input  logic                        iosf_cdc_clock,
    input  logic                        i_rst_n,
    input  logic [N_IOSF_CDC*ISM_W-1:0] i_iosf_ism_fabric,     // Flattened ISM states
    input  logic [N_IOSF_CDC-1:0]       i_iosf_clkreq,
    input  logic [N_NON_IOSF_CDC-1:0]   i_non_iosf_clkreq,
    input  logic [N_IOSF_CDC-1:0]       i_iosf_clkack,
    input  logic [N_NON_IOSF_CDC-1:0]   i_non_iosf_clkack,
    input  logic [N_IOSF_GCLK-1:0]      i_iosf_gclock_req,
    input  logic [N_NON_IOSF_GCLK-1:0]  i_non_iosf_gclock_req,
    input  logic [N_IOSF_GCLK-1:0]      i_iosf_gclock_ack,
    input  logic [N_NON_IOSF_GCLK-1:0]  i_non_iosf_gclock_ack,
    input  logic                        i_pwrgate_disabled,
    input  logic                        i_pmc_wake,
    input  logic                        i_pgcb_idle,
    output logic                        o_wake_ess,            // Always keeps clock on
    output logic                        o_wake_acc             // Counts only with pok
);

    logic [N_IOSF_CDC-1:0] ism_nz;
    logic [N_IOSF_CDC-1:0] ism_act_q;   // Registered per-CDC ISM activity
    logic                  pg_q;        // Last sampled pwrgate_disabled
    logic                  pg_chg_q;    // One-cycle change pulse
    logic                  ism_wake, greq_wake, gack_wake, creq_wake, cack_wake;
    logic                  pgchg_wake, busy_wake, pmc_wake;

    // Any non-idle ISM state per CDC
    for (genvar i = 0; i < N_IOSF_CDC; i++) begin : g_ism
        assign ism_nz[i] = |i_iosf_ism_fabric[i*ISM_W +: ISM_W];
    end

    always_ff @(posedge iosf_cdc_clock) begin
        if (!i_rst_n) begin
            ism_act_q <= '0;
            pg_chg_q  <= 1'b0;
        end else begin
            ism_act_q <= ism_nz;
            pg_chg_q  <= i_pwrgate_disabled ^ pg_q;   // Either edge wakes
        end
    end

    // Tracks through reset, so no false change at release
    always_ff @(posedge iosf_cdc_clock) begin
        pg_q <= i_pwrgate_disabled;
    end

    // Accessible sources
    cg_wake_extend #(.N(N_IOSF_CDC)) u_ext_ism (
        .iosf_cdc_clock(iosf_cdc_clock), .i_rst_n(i_rst_n),
        .i_async(ism_act_q), .o_wake_any(ism_wake));
    cg_wake_extend #(.N(N_GCLK)) u_ext_greq (
        .iosf_cdc_clock(iosf_cdc_clock), .i_rst_n(i_rst_n),
        .i_async({i_non_iosf_gclock_req, i_iosf_gclock_req}), .o_wake_any(greq_wake));
    cg_wake_extend #(.N(N_GCLK)) u_ext_gack (
        .iosf_cdc_clock(iosf_cdc_clock), .i_rst_n(i_rst_n),
        .i_async({i_non_iosf_gclock_ack, i_iosf_gclock_ack}), .o_wake_any(gack_wake));
    cg_wake_extend #(.N(1)) u_ext_pgchg (
        .iosf_cdc_clock(iosf_cdc_clock), .i_rst_n(i_rst_n),
        .i_async(pg_chg_q), .o_wake_any(pgchg_wake));

    // Essential sources
    cg_wake_extend #(.N(N_CDC)) u_ext_creq (
        .iosf_cdc_clock(iosf_cdc_clock), .i_rst_n(i_rst_n),
        .i_async({i_non_iosf_clkreq, i_iosf_clkreq}), .o_wake_any(creq_wake));
    cg_wake_extend #(.N(N_CDC)) u_ext_cack (
        .iosf_cdc_clock(iosf_cdc_clock), .i_rst_n(i_rst_n),
        .i_async({i_non_iosf_clkack, i_iosf_clkack}), .o_wake_any(cack_wake));
    cg_wake_extend #(.N(1)) u_ext_busy (
        .iosf_cdc_clock(iosf_cdc_clock), .i_rst_n(i_rst_n),
        .i_async(~i_pgcb_idle), .o_wake_any(busy_wake));      // PGCB not idle
    cg_wake_extend #(.N(1)) u_ext_pmc (
        .iosf_cdc_clock(iosf_cdc_clock), .i_rst_n(i_rst_n),
        .i_async(i_pmc_wake), .o_wake_any(pmc_wake));

    assign o_wake_ess = creq_wake | cack_wake | pmc_wake | busy_wake;
    assign o_wake_acc = ism_wake | greq_wake | gack_wake | pgchg_wake;

endmodule
